// ==== source/ines_pkg.sv ====
// iNES image format constants and the types for the parsed header and the boot stream
`default_nettype none

package ines_pkg;

    localparam logic [31:0] INES_SIGNATURE      = 32'h4E45_531A; // "NES" and 1Ah
    localparam int unsigned INES_HEADER_BYTES   = 16;
    localparam int unsigned PRG_BANK_BYTES_LOG2 = 14;            // 16 KB banks
    localparam int unsigned CHR_BANK_BYTES_LOG2 = 13;            // 8 KB banks
    localparam int unsigned BANK_COUNT_W        = 6;
    localparam int unsigned ROM_OFFSET_W        = 19;

    typedef logic [ROM_OFFSET_W-1:0] rom_offset_t;

    typedef struct packed {
        logic [BANK_COUNT_W-1:0] prg_banks;
        logic [BANK_COUNT_W-1:0] chr_banks;
        logic                    chr_is_rom;      // Zero CHR banks means CHR RAM
        logic                    vertical_layout; // Flags 6 bit 0
        logic                    alt_layout;      // Flags 6 bit 3
        logic [7:0]              mapper;
    } ines_header_t;

    typedef struct packed {
        logic        valid;
        logic        is_chr;
        rom_offset_t offset;  // Offset inside PRG or CHR
        logic [7:0]  data;
    } boot_data_t;

    typedef struct packed {
        logic booting;
        logic prg_received;
        logic chr_received;
        logic complete;
        logic failed;
    } boot_status_t;

endpackage

`default_nettype wire

// ==== source/sd_read_pkg.sv ====
// SD block reader interface: block geometry and the request, byte and status types
`default_nettype none

package sd_read_pkg;

    localparam int unsigned SD_BLOCK_BYTES       = 512;
    localparam int unsigned SD_BLOCK_IDX_W       = 9;
    localparam int unsigned SD_BLOCK_ADDR_W      = 32;
    localparam int unsigned BLOCKS_PER_GAME_LOG2 = 11; // 1 MB slot per game

    typedef struct packed {
        logic                       start;      // One-cycle pulse
        logic [SD_BLOCK_ADDR_W-1:0] block_addr;
    } sd_read_req_t;

    typedef struct packed {
        logic                      valid;
        logic [SD_BLOCK_IDX_W-1:0] index; // Byte position inside the block
        logic [7:0]                data;
    } sd_byte_t;

    typedef struct packed {
        logic idle;
        logic ok;   // Meaningful when idle rises
    } sd_status_t;

endpackage

`default_nettype wire

// ==== source/ines_header_parser.sv ====
// iNES header parser: latches header fields by byte index and checks the signature
`timescale 1ns/1ns
`default_nettype none

module ines_header_parser (
    input  wire                     clk_i,
    input  wire                     rst_i,
    input  wire                     capture_i,
    input  wire sd_read_pkg::sd_byte_t sd_byte_i,
    output ines_pkg::ines_header_t  header_o,
    output logic                    sign_ok_o
);

    logic [31:0]                       sign_r;
    logic [ines_pkg::BANK_COUNT_W-1:0] prg_banks_r;
    logic [ines_pkg::BANK_COUNT_W-1:0] chr_banks_r;
    logic                              vertical_r;
    logic                              alt_layout_r;
    logic [3:0]                        mapper_lo_r;
    logic [3:0]                        mapper_hi_r;
    logic                              sign_ok_r;
    logic                              take;

    assign take = capture_i && sd_byte_i.valid;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            prg_banks_r <= '0;
            chr_banks_r <= '0;
            sign_ok_r   <= 1'b0;
        end else if (take) begin
            case (sd_byte_i.index)
                9'd4: begin
                    prg_banks_r <= sd_byte_i.data[ines_pkg::BANK_COUNT_W-1:0];
                    sign_ok_r   <= (sign_r == ines_pkg::INES_SIGNATURE); // All 4 bytes are in
                end
                9'd5:    chr_banks_r <= sd_byte_i.data[ines_pkg::BANK_COUNT_W-1:0];
                default: ;
            endcase
        end
    end

    // Signature and flag bytes
    always_ff @(posedge clk_i) begin
        if (take) begin
            case (sd_byte_i.index)
                9'd0: sign_r[31:24] <= sd_byte_i.data;
                9'd1: sign_r[23:16] <= sd_byte_i.data;
                9'd2: sign_r[15:8]  <= sd_byte_i.data;
                9'd3: sign_r[7:0]   <= sd_byte_i.data;
                9'd6: begin
                    vertical_r   <= sd_byte_i.data[0];
                    alt_layout_r <= sd_byte_i.data[3];
                    mapper_lo_r  <= sd_byte_i.data[7:4];
                end
                9'd7:    mapper_hi_r <= sd_byte_i.data[7:4];
                default: ;
            endcase
        end
    end

    assign header_o.prg_banks       = prg_banks_r;
    assign header_o.chr_banks       = chr_banks_r;
    assign header_o.chr_is_rom      = |chr_banks_r;
    assign header_o.vertical_layout = vertical_r;
    assign header_o.alt_layout      = alt_layout_r;
    assign header_o.mapper          = {mapper_hi_r, mapper_lo_r};
    assign sign_ok_o                = sign_ok_r;

endmodule

`default_nettype wire

// ==== source/boot_credit_counter.sv ====
// Credit counter: byte slots granted by the memory loader minus boot bytes sent
`timescale 1ns/1ns
`default_nettype none

module boot_credit_counter (
    input  wire  clk_i,
    input  wire  rst_i,
    input  wire  credit_i,
    input  wire  consume_i,
    output logic full_o
);

    typedef logic [sd_read_pkg::SD_BLOCK_IDX_W:0] count_t; // Holds 0 to a full block

    count_t count_r;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            count_r <= '0;                                  // Loader grants from zero
        end else begin
            case ({credit_i, consume_i})
                2'b10:   count_r <= count_r + 1'b1;
                2'b01:   count_r <= count_r - 1'b1;
                default: count_r <= count_r;                // Both or neither cancel out
            endcase
        end
    end

    // A block may only start once all of its bytes have room
    assign full_o = (count_r >= count_t'(sd_read_pkg::SD_BLOCK_BYTES));

endmodule

`default_nettype wire

// ==== source/boot_sequencer.sv ====
// Boot sequencer: requests SD blocks and streams PRG then CHR bytes with their offsets
`timescale 1ns/1ns
`default_nettype none

module boot_sequencer (
    input  wire [7:0]                    game_index_i,
    input  wire                          clk_i,
    input  wire                          rst_i,
    output sd_read_pkg::sd_read_req_t    sd_req_o,
    input  wire sd_read_pkg::sd_byte_t   sd_byte_i,
    input  wire sd_read_pkg::sd_status_t sd_status_i,
    input  wire ines_pkg::ines_header_t  header_i,
    input  wire                          sign_ok_i,
    input  wire                          credits_full_i,
    output logic                         capture_o,
    output logic                         consume_o,
    output ines_pkg::boot_data_t         boot_data_o,
    output ines_pkg::boot_status_t       status_o
);

    typedef enum logic [3:0] {
        ST_WAIT_READY, ST_PREP_HEADER, ST_READ_HEADER,
        ST_IDLE, ST_PREP_DATA, ST_READ_DATA,
        ST_CHECK_BLOCK, ST_FAILED, ST_FINISHED
    } state_t;

    typedef logic [ines_pkg::ROM_OFFSET_W:0]         size_t;
    typedef logic [sd_read_pkg::SD_BLOCK_ADDR_W-1:0] addr_t;
    typedef logic [sd_read_pkg::SD_BLOCK_IDX_W-1:0]  idx_t;

    state_t                state_r;
    state_t                state_next;
    logic [7:0]            game_index_r;
    logic                  first_cycle_r;
    logic                  start_r;
    addr_t                 block_addr_r;
    logic                  busy_seen_r;   // Reader has left idle for this block
    logic                  block_ok_r;
    ines_pkg::rom_offset_t offset_r;
    logic                  prg_rcvd_r;
    logic                  chr_rcvd_r;
    logic                  out_valid_r;
    logic                  out_is_chr_r;
    ines_pkg::rom_offset_t out_offset_r;
    logic [7:0]            out_data_r;
    size_t                 prg_bytes;
    size_t                 chr_bytes;
    size_t                 offset_inc;
    logic                  ready;
    logic                  hdr_done;
    logic                  block_end;
    logic                  done;
    logic                  send;
    logic                  prg_last;
    logic                  chr_last;

    assign ready     = sd_status_i.idle && credits_full_i;
    assign hdr_done  = sd_byte_i.valid && (sd_byte_i.index == idx_t'(ines_pkg::INES_HEADER_BYTES - 1));
    assign block_end = busy_seen_r && sd_status_i.idle;
    assign done      = prg_rcvd_r && chr_rcvd_r;
    assign send      = sd_byte_i.valid && (state_r == ST_READ_DATA) && sign_ok_i && !done;

    assign prg_bytes  = size_t'(header_i.prg_banks) << ines_pkg::PRG_BANK_BYTES_LOG2;
    assign chr_bytes  = size_t'(header_i.chr_banks) << ines_pkg::CHR_BANK_BYTES_LOG2;
    assign offset_inc = size_t'(offset_r) + 1'b1;
    assign prg_last   = (offset_inc == prg_bytes);
    assign chr_last   = (offset_inc == chr_bytes);

    always_comb begin
        state_next = state_r;
        case (state_r)
            ST_WAIT_READY:  if (ready) state_next = ST_PREP_HEADER;
            ST_PREP_HEADER: state_next = ST_READ_HEADER;
            ST_READ_HEADER: if (hdr_done) state_next = ST_READ_DATA; // Rest of block is PRG
            ST_IDLE:        if (ready) state_next = ST_PREP_DATA;
            ST_PREP_DATA:   state_next = ST_READ_DATA;
            ST_READ_DATA:   if (block_end) state_next = ST_CHECK_BLOCK;
            ST_CHECK_BLOCK: begin
                if (done)
                    state_next = ST_FINISHED;
                else if (!block_ok_r || !sign_ok_i)
                    state_next = ST_FAILED;
                else
                    state_next = ST_IDLE;
            end
            default:        state_next = state_r;               // Failed and finished hold
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_r       <= ST_WAIT_READY;
            first_cycle_r <= 1'b1;
            start_r       <= 1'b0;
            busy_seen_r   <= 1'b0;
            offset_r      <= '0;
            prg_rcvd_r    <= 1'b0;
            chr_rcvd_r    <= 1'b0;
            out_valid_r   <= 1'b0;
        end else begin
            state_r       <= state_next;
            first_cycle_r <= 1'b0;
            start_r       <= (state_r == ST_PREP_HEADER) || (state_r == ST_PREP_DATA);
            out_valid_r   <= send;
            if ((state_r == ST_PREP_HEADER) || (state_r == ST_PREP_DATA))
                busy_seen_r <= 1'b0;
            else if (!sd_status_i.idle)
                busy_seen_r <= 1'b1;
            if (send && !prg_rcvd_r) begin
                offset_r   <= prg_last ? '0 : offset_inc[ines_pkg::ROM_OFFSET_W-1:0];
                prg_rcvd_r <= prg_last;                          // CHR restarts at offset 0
            end else if (send) begin
                offset_r <= offset_inc[ines_pkg::ROM_OFFSET_W-1:0];
                if (chr_last)
                    chr_rcvd_r <= 1'b1;
            end
            if ((state_r == ST_READ_DATA) && !header_i.chr_is_rom)
                chr_rcvd_r <= 1'b1;                              // CHR RAM needs no data
        end
    end

    always_ff @(posedge clk_i) begin
        if (first_cycle_r)
            game_index_r <= game_index_i;
        if (state_r == ST_PREP_HEADER)
            block_addr_r <= addr_t'(game_index_r) << sd_read_pkg::BLOCKS_PER_GAME_LOG2;
        else if (state_r == ST_PREP_DATA)
            block_addr_r <= block_addr_r + 1'b1;
        if ((state_r == ST_READ_DATA) && block_end)
            block_ok_r <= sd_status_i.ok;                        // Sampled as idle rises
        out_is_chr_r <= prg_rcvd_r;
        out_offset_r <= offset_r;
        out_data_r   <= sd_byte_i.data;
    end

    assign sd_req_o.start      = start_r;
    assign sd_req_o.block_addr = block_addr_r;
    assign capture_o           = (state_r == ST_READ_HEADER);
    assign consume_o           = send;

    assign boot_data_o.valid  = out_valid_r;
    assign boot_data_o.is_chr = out_is_chr_r;
    assign boot_data_o.offset = out_offset_r;
    assign boot_data_o.data   = out_data_r;

    assign status_o.booting      = !done && (state_r != ST_FAILED);
    assign status_o.prg_received = prg_rcvd_r;
    assign status_o.chr_received = chr_rcvd_r;
    assign status_o.complete     = done;
    assign status_o.failed       = (state_r == ST_FAILED);

endmodule

`default_nettype wire

// ==== source/nes_boot_top.sv ====
// NES game loader top: header parser, boot sequencer and credit counter
`timescale 1ns/1ns
`default_nettype none

module nes_boot_top (
    input  wire                          clk_i,
    input  wire                          rst_i,
    input  wire [7:0]                    game_index_i,
    output sd_read_pkg::sd_read_req_t    sd_req_o,
    input  wire sd_read_pkg::sd_byte_t   sd_byte_i,
    input  wire sd_read_pkg::sd_status_t sd_status_i,
    input  wire                          credit_i,
    output ines_pkg::boot_data_t         boot_data_o,
    output ines_pkg::ines_header_t       header_o,
    output ines_pkg::boot_status_t       status_o
);

    logic capture;
    logic sign_ok;
    logic consume;
    logic credits_full;

    ines_header_parser u_parser (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .capture_i (capture),
        .sd_byte_i (sd_byte_i),
        .header_o  (header_o),
        .sign_ok_o (sign_ok)
    );

    boot_credit_counter u_credits (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .credit_i  (credit_i),
        .consume_i (consume),
        .full_o    (credits_full)
    );

    boot_sequencer u_sequencer (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .game_index_i   (game_index_i),
        .sd_req_o       (sd_req_o),
        .sd_byte_i      (sd_byte_i),
        .sd_status_i    (sd_status_i),
        .header_i       (header_o),     // Parsed fields feed the size counters
        .sign_ok_i      (sign_ok),
        .credits_full_i (credits_full),
        .capture_o      (capture),
        .consume_o      (consume),
        .boot_data_o    (boot_data_o),
        .status_o       (status_o)
    );

endmodule

`default_nettype wire

// ==== dv/boot_sva.sv ====
// Protocol assertions on the boot sequencer block requests and status
`timescale 1ns/1ns
`default_nettype none

module boot_sva (
    input wire                            clk_i,
    input wire                            rst_i,
    input wire sd_read_pkg::sd_read_req_t sd_req_i,
    input wire sd_read_pkg::sd_status_t   sd_status_i,
    input wire                            credits_full_i,
    input wire ines_pkg::boot_status_t    status_i
);

    int failures = 0;

    start_needs_room: assert property (@(posedge clk_i) disable iff (rst_i)
        sd_req_i.start |-> $past(credits_full_i, 2) && $past(sd_status_i.idle, 2))
        else begin
            $error("Block start without full credits and an idle reader");
            failures++;
        end

    start_one_cycle: assert property (@(posedge clk_i) disable iff (rst_i)
        sd_req_i.start |=> !sd_req_i.start)
        else begin
            $error("Block start wider than one cycle");
            failures++;
        end

    end_exclusive: assert property (@(posedge clk_i) disable iff (rst_i)
        !(status_i.complete && status_i.failed))
        else begin
            $error("Complete and failed high together");
            failures++;
        end

endmodule

bind boot_sequencer boot_sva u_sva (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .sd_req_i       (sd_req_o),
    .sd_status_i    (sd_status_i),
    .credits_full_i (credits_full_i),
    .status_i       (status_o)
);

`default_nettype wire

// ==== dv/boot_checker.sv ====
// Boot checker: compares requests, header, boot stream and status with the expected game
`timescale 1ns/1ns
`default_nettype none

module boot_checker (
    input  wire                            clk_i,
    input  wire                            rst_i,
    input  wire [7:0]                      game_i,
    input  wire                            sig_good_i,
    input  wire [5:0]                      prg_banks_i,
    input  wire [5:0]                      chr_banks_i,
    input  wire [7:0]                      exp_mapper_i,
    input  wire                            exp_vert_i,
    input  wire                            exp_alt_i,
    input  wire                            exp_fail_i,
    input  wire                            credit_i,
    input  wire sd_read_pkg::sd_read_req_t sd_req_i,
    input  wire ines_pkg::boot_data_t      boot_data_i,
    input  wire ines_pkg::ines_header_t    header_i,
    input  wire ines_pkg::boot_status_t    status_i,
    output int                             errors_o
);

    int          errors = 0;
    logic [31:0] lfsr_r;
    int unsigned prg_cnt;
    int unsigned chr_cnt;
    int unsigned granted;
    int unsigned sent;
    int unsigned blocks;
    logic        ended;

    assign errors_o = errors;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic report(input string msg);
        errors++;
        $display("** Error at %0t ns: %s", $time, msg);
    endtask

    always @(posedge clk_i) begin
        logic [7:0]  exp_data;
        int unsigned prg_size;
        int unsigned chr_size;
        prg_size = int'(prg_banks_i) * 16384;
        chr_size = int'(chr_banks_i) * 8192;
        if (rst_i) begin
            lfsr_r  = 32'h3096fe23; // Same seed as the image generator
            prg_cnt = 0;
            chr_cnt = 0;
            granted = 0;
            sent    = 0;
            blocks  = 0;
            ended   = 1'b0;
        end else begin
            if (credit_i)
                granted++;
            if (sd_req_i.start) begin
                if (sd_req_i.block_addr != int'(game_i) * 2048 + blocks)
                    report($sformatf("block address %0d, expected %0d",
                                     sd_req_i.block_addr, int'(game_i) * 2048 + blocks));
                if (granted - sent < 512)
                    report($sformatf("start with only %0d credits", granted - sent));
                blocks++;
            end
            if (boot_data_i.valid) begin
                sent++;
                for (int k = 0; k < 8; k++) begin
                    lfsr_r   = lfsr_next(lfsr_r);
                    exp_data = {exp_data[6:0], lfsr_r[0]};
                end
                if (ended)
                    report("boot data after the boot ended");
                if (!sig_good_i)
                    report("boot data sent for a bad signature");
                if (sent > granted)
                    report($sformatf("%0d bytes sent on %0d credits", sent, granted));
                if (boot_data_i.data != exp_data)
                    report($sformatf("data %h, expected %h", boot_data_i.data, exp_data));
                if (prg_cnt < prg_size) begin
                    if (boot_data_i.is_chr || boot_data_i.offset != prg_cnt)
                        report($sformatf("PRG byte chr=%b offset %0d, expected %0d",
                                         boot_data_i.is_chr, boot_data_i.offset, prg_cnt));
                    prg_cnt++;
                end else if (chr_cnt < chr_size) begin
                    if (!boot_data_i.is_chr || boot_data_i.offset != chr_cnt)
                        report($sformatf("CHR byte chr=%b offset %0d, expected %0d",
                                         boot_data_i.is_chr, boot_data_i.offset, chr_cnt));
                    chr_cnt++;
                end else begin
                    report("byte beyond the ROM size");
                end
            end
            if (chr_banks_i == 0 && status_i.prg_received && !status_i.chr_received)
                report("CHR RAM game has PRG received before CHR");
            if (status_i.prg_received != (prg_cnt == prg_size))
                report($sformatf("prg_received %b after %0d PRG bytes",
                                 status_i.prg_received, prg_cnt));
            if (chr_banks_i != 0 && status_i.chr_received != (chr_cnt == chr_size))
                report($sformatf("chr_received %b after %0d CHR bytes",
                                 status_i.chr_received, chr_cnt));
            if (status_i.complete != (prg_cnt == prg_size && chr_cnt == chr_size))
                report($sformatf("complete %b after %0d PRG and %0d CHR bytes",
                                 status_i.complete, prg_cnt, chr_cnt));
            if (status_i.booting == (status_i.complete || status_i.failed))
                report($sformatf("booting %b with complete %b failed %b", status_i.booting,
                                 status_i.complete, status_i.failed));
            if ((status_i.complete || status_i.failed) && !ended) begin
                ended = 1'b1;
                if (header_i.mapper != exp_mapper_i || header_i.vertical_layout != exp_vert_i
                    || header_i.alt_layout != exp_alt_i)
                    report($sformatf("header mapper %h v%b a%b", header_i.mapper,
                                     header_i.vertical_layout, header_i.alt_layout));
                if (header_i.prg_banks != prg_banks_i || header_i.chr_banks != chr_banks_i
                    || header_i.chr_is_rom != (chr_banks_i != 0))
                    report("header bank counts differ");
                if (status_i.complete == exp_fail_i)
                    report($sformatf("complete %b failed %b", status_i.complete,
                                     status_i.failed));
            end
        end
    end

endmodule

`default_nettype wire

// ==== dv/tb_boot.sv ====
// Testbench for the NES game loader with an SD block reader model and a credit source
`timescale 1ns/1ns
`default_nettype none

module tb_boot;

    typedef struct packed {
        logic [7:0]  game;
        logic        sig_good;
        logic [5:0]  prg_banks;
        logic [5:0]  chr_banks;
        logic [7:0]  flags6;
        logic [7:0]  flags7;
        logic        sd_ok;
        logic [15:0] withhold;   // Cycles without credits at the row start
        logic [7:0]  exp_mapper;
        logic        exp_vert;
        logic        exp_alt;
        logic        exp_fail;
    } row_t;

    localparam int NUM_ROWS     = 5;
    localparam int BOOT_TIMEOUT = 300000;

    logic                      clk;
    logic                      rst;
    logic [7:0]                game;
    logic                      credit;
    sd_read_pkg::sd_read_req_t sd_req;
    sd_read_pkg::sd_byte_t     sd_byte;
    sd_read_pkg::sd_status_t   sd_status;
    ines_pkg::boot_data_t      boot_data;
    ines_pkg::ines_header_t    header;
    ines_pkg::boot_status_t    status;
    row_t                      rows [NUM_ROWS];
    row_t                      cur;
    logic [31:0]               rom_lfsr;
    logic [31:0]               rnd_lfsr = 32'h3096fe23;
    int unsigned               granted;
    int unsigned               received;
    int unsigned               row_cycles;
    int                        check_errors;
    int                        assert_errors;
    int                        timeouts = 0;
    int                        cycles;

    nes_boot_top uut (
        .clk_i (clk), .rst_i (rst), .game_index_i (game), .sd_req_o (sd_req),
        .sd_byte_i (sd_byte), .sd_status_i (sd_status), .credit_i (credit),
        .boot_data_o (boot_data), .header_o (header), .status_o (status)
    );

    boot_checker u_checker (
        .clk_i (clk), .rst_i (rst), .game_i (cur.game), .sig_good_i (cur.sig_good),
        .prg_banks_i (cur.prg_banks), .chr_banks_i (cur.chr_banks),
        .exp_mapper_i (cur.exp_mapper), .exp_vert_i (cur.exp_vert), .exp_alt_i (cur.exp_alt),
        .exp_fail_i (cur.exp_fail), .credit_i (credit), .sd_req_i (sd_req),
        .boot_data_i (boot_data), .header_i (header), .status_i (status),
        .errors_o (check_errors)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic int unsigned draw_bits(input int n);
        int unsigned v;
        v = 0;
        for (int k = 0; k < n; k++) begin
            rnd_lfsr = lfsr_next(rnd_lfsr);
            v        = (v << 1) | rnd_lfsr[0];
        end
        return v;
    endfunction

    // Byte p of the game image on the card
    function automatic logic [7:0] image_byte(input int unsigned p);
        logic [7:0] b;
        case (p)
            0:       b = 8'h4E;
            1:       b = 8'h45;
            2:       b = 8'h53;
            3:       b = cur.sig_good ? 8'h1A : 8'h00;
            4:       b = {2'b00, cur.prg_banks};
            5:       b = {2'b00, cur.chr_banks};
            6:       b = cur.flags6;
            7:       b = cur.flags7;
            default: b = 8'h00;
        endcase
        if (p >= 16) begin
            for (int k = 0; k < 8; k++) begin
                rom_lfsr = lfsr_next(rom_lfsr);
                b        = {b[6:0], rom_lfsr[0]};
            end
        end
        return b;
    endfunction

    task automatic serve_block(input logic [31:0] addr);
        int unsigned pos;
        int unsigned gap;
        pos            = (addr - int'(cur.game) * 2048) * 512;
        sd_status.idle = 1'b0;
        for (int i = 0; i < 512; i++) begin
            gap = draw_bits(2);
            repeat (gap == 3 ? 2 : (gap == 2 ? 1 : 0)) begin
                @(negedge clk);
                sd_byte.valid = 1'b0;
            end
            @(negedge clk);
            sd_byte.valid = 1'b1;
            sd_byte.index = i[8:0];
            sd_byte.data  = image_byte(pos + i);
        end
        @(negedge clk);
        sd_byte.valid = 1'b0;
        sd_status     = '{1'b1, cur.sd_ok};  // Ok is read as idle rises
    endtask

    always begin
        @(negedge clk);
        if (!rst && sd_req.start)
            serve_block(sd_req.block_addr);
    end

    // Memory loader model with a 512-byte buffer
    always @(negedge clk) begin
        if (rst) begin
            credit     = 1'b0;
            granted    = 0;
            received   = 0;
            row_cycles = 0;
        end else begin
            row_cycles++;
            if (boot_data.valid)
                received++;
            credit = (row_cycles > cur.withhold) && (granted - received < 512)
                     && (draw_bits(2) != 0);
            if (credit)
                granted++;
        end
    end

    initial begin
        clk       = 1'b0;
        rst       = 1'b1;
        game      = 8'd0;
        credit    = 1'b0;
        sd_byte   = '0;
        sd_status = '{1'b1, 1'b1};
        rows[0] = '{8'd3, 1'b1, 6'd1, 6'd1, 8'h31, 8'h40, 1'b1, 16'd0, 8'h43, 1'b1, 1'b0, 1'b0};
        rows[1] = '{8'd0, 1'b1, 6'd1, 6'd0, 8'h18, 8'h00, 1'b1, 16'd0, 8'h01, 1'b0, 1'b1, 1'b0};
        rows[2] = '{8'd5, 1'b0, 6'd1, 6'd1, 8'h00, 8'h00, 1'b1, 16'd0, 8'h00, 1'b0, 1'b0, 1'b1};
        rows[3] = '{8'd1, 1'b1, 6'd1, 6'd1, 8'h21, 8'h10, 1'b0, 16'd0, 8'h12, 1'b1, 1'b0, 1'b1};
        rows[4] = '{8'd7, 1'b1, 6'd1, 6'd1, 8'h41, 8'h20, 1'b1, 16'd4000, 8'h24, 1'b1, 1'b0,
                    1'b0};
        for (int r = 0; r < NUM_ROWS; r++) begin
            @(negedge clk);
            cur      = rows[r];
            game     = cur.game;
            rom_lfsr = 32'h3096fe23;           // Restart the ROM byte sequence
            rst      = 1'b1;
            repeat (8) @(negedge clk);
            rst    = 1'b0;
            cycles = 0;
            while (!(status.complete || status.failed) && cycles < BOOT_TIMEOUT) begin
                @(negedge clk);
                cycles++;
            end
            if (!(status.complete || status.failed)) begin
                timeouts++;
                $display("Row %0d neither completed nor failed in time", r);
            end
            cycles = 0;
            while (!sd_status.idle && cycles < 5000) begin
                @(negedge clk);
                cycles++;
            end
            if (!sd_status.idle) begin
                timeouts++;
                $display("Row %0d: the SD reader model never went idle", r);
            end
        end
        repeat (2) @(negedge clk);
        assert_errors = uut.u_sequencer.u_sva.failures;
        $display("Checker errors: %0d, assertion failures: %0d, timeouts: %0d",
                 check_errors, assert_errors, timeouts);
        if (check_errors == 0 && assert_errors == 0 && timeouts == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
source/ines_pkg.sv
source/sd_read_pkg.sv
source/ines_header_parser.sv
source/boot_credit_counter.sv
source/boot_sequencer.sv
source/nes_boot_top.sv
dv/boot_sva.sv
dv/boot_checker.sv
dv/tb_boot.sv

// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = tb_boot
FILELIST  = all.f
LOG       = sim.log

.PHONY: compile run clean

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: compile
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "TB FAILED" $(LOG); then exit 1; fi
	@grep -q "TB PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
